//--- rtl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    localparam int BYTE  = 8;
    localparam int DWORD = 32;

    // Opcodes seen by the fetch unit
    localparam logic [5:0] OP_HALT = 6'b111111;
    localparam logic [5:0] OP_JUMP = 6'b000010;

    // Host command bytes
    localparam logic [BYTE-1:0] CMD_LOAD = 8'h01;
    localparam logic [BYTE-1:0] CMD_RUN  = 8'h02;
    localparam logic [BYTE-1:0] CMD_STEP = 8'h03;
    localparam logic [BYTE-1:0] CMD_DUMP = 8'h04;

    // One instruction word, decoded as fields or as serial bytes
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } fields;
        logic [3:0][BYTE-1:0] bytes;    // Index 0 is the LSB
    } instr_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        RUN,
        STEP,
        DUMP_ADDR,
        SEND
    } dbg_state_t;

endpackage

`default_nettype wire

//--- rtl/baud_gen.sv
`default_nettype none

module baud_gen #(
    parameter int DIVISOR = 27
) (
    input  logic i_clock,
    input  logic i_arst_n,
    output logic o_tick
);

    localparam int CW = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == CW'(DIVISOR - 1)) begin
            count  <= '0;
            o_tick <= 1'b1;         // One pulse per wrap
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_tick,
    input  logic                     i_rx,
    output logic [dbg_pkg::BYTE-1:0] o_rx_data,
    output logic                     o_rx_done
);

    import dbg_pkg::*;

    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic [1:0]      rx_sync;
    logic [1:0]      state;
    logic [3:0]      tick_cnt;
    logic [2:0]      bit_cnt;
    logic [BYTE-1:0] shift;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_sync <= 2'b11;       // Line idles high
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync[1]) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd7) begin
                            // Mid start bit, drop glitches
                            state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= RX_STOP;
                            end
                        end
                    end
                end
                default: begin  // RX_STOP
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            state     <= RX_IDLE;
                            o_rx_done <= rx_sync[1];  // Framing error drops the byte
                        end
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && i_tick && tick_cnt == 4'd15) begin
            shift <= {rx_sync[1], shift[BYTE-1:1]};
        end
    end

    assign o_rx_data = shift;

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_tick,
    input  logic [dbg_pkg::BYTE-1:0] i_tx_data,
    input  logic                     i_tx_start,
    output logic                     o_tx,
    output logic                     o_tx_done
);

    import dbg_pkg::*;

    localparam logic [1:0] TX_IDLE  = 2'd0;
    localparam logic [1:0] TX_START = 2'd1;
    localparam logic [1:0] TX_DATA  = 2'd2;
    localparam logic [1:0] TX_STOP  = 2'd3;

    logic [1:0]      state;
    logic [3:0]      tick_cnt;
    logic [2:0]      bit_cnt;
    logic [BYTE-1:0] shift;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (i_tx_start) begin
                        state    <= TX_START;
                        tick_cnt <= '0;
                        o_tx     <= 1'b0;   // Start bit
                    end
                end
                TX_START: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            state   <= TX_DATA;
                            bit_cnt <= '0;
                            o_tx    <= shift[0];
                        end
                    end
                end
                TX_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= TX_STOP;
                                o_tx  <= 1'b1;
                            end else begin
                                o_tx <= shift[1];  // Next bit before the shift lands
                            end
                        end
                    end
                end
                default: begin  // TX_STOP
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            state     <= TX_IDLE;
                            o_tx_done <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == TX_IDLE && i_tx_start) begin
            shift <= i_tx_data;
        end else if (state == TX_DATA && i_tick && tick_cnt == 4'd15) begin
            shift <= shift >> 1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_mem.sv
`default_nettype none

module instr_mem #(
    parameter int ADDR = 6
) (
    input  logic                      i_clock,
    input  logic                      i_we,
    input  logic [ADDR-1:0]           i_waddr,
    input  logic [dbg_pkg::DWORD-1:0] i_wdata,
    input  logic [ADDR-1:0]           i_raddr_a,
    output logic [dbg_pkg::DWORD-1:0] o_rdata_a,
    input  logic [ADDR-1:0]           i_raddr_b,
    output logic [dbg_pkg::DWORD-1:0] o_rdata_b
);

    import dbg_pkg::*;

    logic [DWORD-1:0] mem [2**ADDR];

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Port A feeds fetch, port B serves dumps
    assign o_rdata_a = mem[i_raddr_a];
    assign o_rdata_b = mem[i_raddr_b];

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter int ADDR = 6
) (
    input  logic            i_clock,
    input  logic            i_arst_n,
    input  logic            i_run,
    input  logic            i_step,
    input  logic            i_pc_clear,
    input  dbg_pkg::instr_t i_instr,
    output logic [ADDR-1:0] o_pc,
    output logic            o_hlt
);

    import dbg_pkg::*;

    logic advance;
    logic is_halt;
    logic hlt_q;

    assign advance = (i_run | i_step) & ~hlt_q;
    assign is_halt = (i_instr.fields.opcode == OP_HALT);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc  <= '0;
            hlt_q <= 1'b0;
        end else if (i_pc_clear) begin
            o_pc  <= '0;
            hlt_q <= 1'b0;
        end else if (advance) begin
            case (i_instr.fields.opcode)
                OP_HALT: begin
                    hlt_q <= 1'b1;  // PC stays on the halt word
                end
                OP_JUMP: begin
                    o_pc <= i_instr.fields.imm[ADDR-1:0];
                end
                default: begin
                    o_pc <= o_pc + 1'b1;
                end
            endcase
        end
    end

    // Visible in the cycle the halt is fetched
    assign o_hlt = hlt_q | (advance & is_halt);

endmodule

`default_nettype wire

//--- rtl/debug_unit.sv
`default_nettype none

module debug_unit #(
    parameter int ADDR = 6
) (
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic [dbg_pkg::BYTE-1:0]  i_rx_data,
    input  logic                      i_rx_done,
    input  logic                      i_tx_done,
    output logic [dbg_pkg::BYTE-1:0]  o_tx_data,
    output logic                      o_tx_start,
    output logic                      o_im_we,
    output logic [ADDR-1:0]           o_im_waddr,
    output logic [dbg_pkg::DWORD-1:0] o_im_wdata,
    output logic [ADDR-1:0]           o_dump_addr,
    input  logic [dbg_pkg::DWORD-1:0] i_dump_data,
    input  logic [ADDR-1:0]           i_pc,
    input  logic                      i_hlt,
    output logic                      o_run,
    output logic                      o_step,
    output logic                      o_pc_clear,
    output dbg_pkg::dbg_state_t       o_state
);

    import dbg_pkg::*;

    dbg_state_t      state;
    instr_t          load_word;
    instr_t          next_word;
    instr_t          reply;
    logic [1:0]      byte_idx;      // Load and send both walk bytes 0..3
    logic [ADDR-1:0] load_addr;
    logic            tx_busy;

    always_comb begin
        next_word = load_word;
        next_word.bytes[byte_idx] = i_rx_data;
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= IDLE;
            byte_idx   <= '0;
            load_addr  <= '0;
            tx_busy    <= 1'b0;
            o_tx_start <= 1'b0;
            o_im_we    <= 1'b0;
            o_run      <= 1'b0;
            o_step     <= 1'b0;
            o_pc_clear <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_im_we    <= 1'b0;
            o_pc_clear <= 1'b0;
            if (i_tx_done) begin
                tx_busy <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                state     <= LOAD;
                                load_addr <= '0;
                                byte_idx  <= '0;
                            end
                            CMD_RUN: begin
                                state <= RUN;
                                o_run <= 1'b1;
                            end
                            CMD_STEP: begin
                                state  <= STEP;
                                o_step <= 1'b1;
                            end
                            CMD_DUMP: state <= DUMP_ADDR;
                            default: ;      // Unknown command ignored
                        endcase
                    end
                end
                LOAD: begin
                    if (i_rx_done) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            o_im_we   <= 1'b1;
                            load_addr <= load_addr + 1'b1;
                            // Opcode sits in the top six bits of byte 3
                            if (next_word.bytes[3][7:2] == OP_HALT || load_addr == '1) begin
                                o_pc_clear <= 1'b1;
                                state      <= IDLE;
                            end
                        end
                    end
                end
                RUN: begin
                    if (i_hlt) begin
                        o_run <= 1'b0;
                        state <= SEND;
                    end
                end
                STEP: begin
                    if (o_step) begin
                        o_step <= 1'b0;     // Let the PC settle
                    end else begin
                        state <= SEND;
                    end
                end
                DUMP_ADDR: begin
                    if (i_rx_done) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        tx_busy    <= 1'b1;
                    end else if (i_tx_done) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == LOAD && i_rx_done) begin
            load_word  <= next_word;
            o_im_wdata <= next_word;
            o_im_waddr <= load_addr;
        end
        if ((state == RUN && i_hlt) || (state == STEP && !o_step)) begin
            reply <= {{(DWORD - ADDR){1'b0}}, i_pc};
        end else if (state == DUMP_ADDR && i_rx_done) begin
            reply <= i_dump_data;
        end
        if (state == SEND && !tx_busy) begin
            o_tx_data <= reply.bytes[byte_idx];
        end
    end

    assign o_dump_addr = i_rx_data[ADDR-1:0];   // Receiver holds the address byte
    assign o_state     = state;

endmodule

`default_nettype wire

//--- rtl/dbg_top.sv
`default_nettype none

module dbg_top #(
    parameter int ADDR    = 6,
    parameter int DIVISOR = 27
) (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_uart_rx,
    output logic                o_uart_tx,
    output logic                o_hlt,
    output dbg_pkg::dbg_state_t o_state
);

    import dbg_pkg::*;

    logic             tick;
    logic [BYTE-1:0]  rx_data;
    logic             rx_done;
    logic [BYTE-1:0]  tx_data;
    logic             tx_start;
    logic             tx_done;

    logic             im_we;
    logic [ADDR-1:0]  im_waddr;
    logic [DWORD-1:0] im_wdata;
    logic [ADDR-1:0]  dump_addr;
    logic [DWORD-1:0] dump_data;

    logic [ADDR-1:0]  pc;
    instr_t           fetch_word;
    logic             run;
    logic             step;
    logic             pc_clear;

    baud_gen #(
        .DIVISOR(DIVISOR)
    ) u_baud_gen (
        .i_clock (i_clock),
        .i_arst_n(i_arst_n),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_tick   (tick),
        .i_rx     (i_uart_rx),
        .o_rx_data(rx_data),
        .o_rx_done(rx_done)
    );

    uart_tx u_uart_tx (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_tick    (tick),
        .i_tx_data (tx_data),
        .i_tx_start(tx_start),
        .o_tx      (o_uart_tx),
        .o_tx_done (tx_done)
    );

    instr_mem #(
        .ADDR(ADDR)
    ) u_instr_mem (
        .i_clock  (i_clock),
        .i_we     (im_we),
        .i_waddr  (im_waddr),
        .i_wdata  (im_wdata),
        .i_raddr_a(pc),
        .o_rdata_a(fetch_word),
        .i_raddr_b(dump_addr),
        .o_rdata_b(dump_data)
    );

    fetch_unit #(
        .ADDR(ADDR)
    ) u_fetch_unit (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_run     (run),
        .i_step    (step),
        .i_pc_clear(pc_clear),
        .i_instr   (fetch_word),
        .o_pc      (pc),
        .o_hlt     (o_hlt)
    );

    debug_unit #(
        .ADDR(ADDR)
    ) u_debug_unit (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_im_we    (im_we),
        .o_im_waddr (im_waddr),
        .o_im_wdata (im_wdata),
        .o_dump_addr(dump_addr),
        .i_dump_data(dump_data),
        .i_pc       (pc),
        .i_hlt      (o_hlt),
        .o_run      (run),
        .o_step     (step),
        .o_pc_clear (pc_clear),
        .o_state    (o_state)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
    end

    always #(PERIOD / 2) o_clock = ~o_clock;

endmodule

`default_nettype wire

//--- tests/dbg_asserts.sv
`default_nettype none

module dbg_asserts #(
    parameter int ADDR = 6
) (
    input logic            i_clock,
    input logic            i_arst_n,
    input logic            i_tx_start,
    input logic            i_tx_done,
    input logic            i_run,
    input logic            i_step,
    input logic            i_pc_clear,
    input logic [ADDR-1:0] i_pc,
    input logic            i_hlt
);

    logic in_flight;

    // Byte on the wire from start pulse to done pulse
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            in_flight <= 1'b0;
        end else if (i_tx_start) begin
            in_flight <= 1'b1;
        end else if (i_tx_done) begin
            in_flight <= 1'b0;
        end
    end

    tx_start_when_free: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_tx_start |-> !in_flight)
        else $error("tx start raised while a byte is still in flight");

    run_step_exclusive: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !(i_run && i_step))
        else $error("run and step active together");

    // Halted PC only moves on a clear
    pc_held_on_halt: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_hlt && !i_pc_clear) |=> $stable(i_pc))
        else $error("PC moved while halted");

endmodule

bind debug_unit dbg_asserts #(.ADDR(ADDR)) u_dbg_asserts (
    .i_clock   (i_clock),
    .i_arst_n  (i_arst_n),
    .i_tx_start(o_tx_start),
    .i_tx_done (i_tx_done),
    .i_run     (o_run),
    .i_step    (o_step),
    .i_pc_clear(o_pc_clear),
    .i_pc      (i_pc),
    .i_hlt     (i_hlt)
);

// No transmit path inside the fetch unit
bind fetch_unit dbg_asserts #(.ADDR(ADDR)) u_fetch_asserts (
    .i_clock   (i_clock),
    .i_arst_n  (i_arst_n),
    .i_tx_start(1'b0),
    .i_tx_done (1'b0),
    .i_run     (i_run),
    .i_step    (i_step),
    .i_pc_clear(i_pc_clear),
    .i_pc      (o_pc),
    .i_hlt     (o_hlt)
);

`default_nettype wire

//--- tests/tb_dbg_top.sv
`default_nettype none

module tb_dbg_top;

    import dbg_pkg::*;

    localparam int ADDR       = 6;
    localparam int DIVISOR    = 2;
    localparam int MEM_WORDS  = 1 << ADDR;
    localparam int BIT_CLKS   = 16 * DIVISOR;
    localparam int IDLE_LIMIT = 4 * BIT_CLKS;
    localparam int RUN_LIMIT  = 1000;
    localparam int SEED       = 32'h8a32_1a90;

    localparam int LEN_A   = 12;    // Loaded first, also feeds the jump test
    localparam int LEN_J   = 8;
    localparam int LEN_S   = 5;
    localparam int N_STEPS = 7;
    localparam int LEN_R   = 8;

    // Serial bytes both ways over the whole run
    localparam longint TOTAL_BYTES = (1 + 4 * LEN_A) + LEN_A * 6 + 5
                                   + (1 + 4 * LEN_J) + 5
                                   + (1 + 4 * LEN_S) + N_STEPS * 5
                                   + (1 + 4 * LEN_R) + 5;
    localparam longint WATCHDOG_TIME = TOTAL_BYTES * 10 * 32 * 40 * 4;

    typedef logic [DWORD-1:0] prog_t [MEM_WORDS];

    logic       clock;
    logic       arst_n;
    logic       uart_rx;
    logic       uart_tx;
    logic       hlt;
    dbg_state_t state;

    prog_t            image;        // Mirror of what was loaded into memory
    logic [DWORD-1:0] exp_q[$];
    string            name_q[$];
    logic [DWORD-1:0] got_q[$];
    int               n_words    = 0;
    int               n_replies  = 0;
    int               n_expected = 0;
    int               checks     = 0;
    int               errors     = 0;
    string            cur_test   = "reset";

    tb_clock_gen #(
        .PERIOD(40)
    ) u_clock_gen (
        .o_clock(clock)
    );

    dbg_top #(
        .ADDR   (ADDR),
        .DIVISOR(DIVISOR)
    ) u_dut (
        .i_clock  (clock),
        .i_arst_n (arst_n),
        .i_uart_rx(uart_rx),
        .o_uart_tx(uart_tx),
        .o_hlt    (hlt),
        .o_state  (state)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Final PC after at most max_steps enabled cycles
    function automatic int ref_run(input prog_t prog, input int start_pc, input int max_steps);
        int pc;
        int n;
        pc = start_pc;
        for (n = 0; n < max_steps; n++) begin
            if (prog[pc][31:26] == OP_HALT) begin
                break;
            end
            if (prog[pc][31:26] == OP_JUMP) begin
                pc = int'(prog[pc][ADDR-1:0]);
            end else begin
                pc = (pc + 1) % MEM_WORDS;
            end
        end
        return pc;
    endfunction

    function automatic logic [31:0] plain_word();
        logic [31:0] w;
        w = $urandom();
        if (w[31:26] == OP_HALT || w[31:26] == OP_JUMP) begin
            w[31:26] = 6'b000001;
        end
        return w;
    endfunction

    function automatic logic [31:0] halt_word();
        logic [31:0] w;
        w = $urandom();
        w[31:26] = OP_HALT;
        return w;
    endfunction

    function automatic logic [31:0] jump_word(input int target);
        logic [31:0] w;
        w = $urandom();
        w[31:26] = OP_JUMP;
        w[5:0]   = 6'(target);      // Upper imm bits stay random
        return w;
    endfunction

    task automatic build_straight(input int len);
        int i;
        for (i = 0; i < len - 1; i++) begin
            image[i] = plain_word();
        end
        image[len-1] = halt_word();
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clock);
            uart_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clock);
        end
    endtask

    task automatic receive_byte(output logic [7:0] data);
        int i;
        @(negedge clock);
        while (uart_tx !== 1'b0) begin
            @(negedge clock);
        end
        repeat (BIT_CLKS / 2) @(negedge clock);    // Middle of start bit
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clock);
            data[i] = uart_tx;
        end
        repeat (BIT_CLKS) @(negedge clock);
        check({cur_test, " stop bit"}, 32'd1, {31'd0, uart_tx});
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        @(negedge clock);
        while (state != IDLE && n < IDLE_LIMIT) begin
            @(negedge clock);
            n++;
        end
        check({name, " state"}, 32'(IDLE), 32'(state));
    endtask

    task automatic load_program(input int len);
        int w;
        int k;
        send_byte(CMD_LOAD);
        for (w = 0; w < len; w++) begin
            for (k = 0; k < 4; k++) begin
                send_byte(image[w][8*k +: 8]);     // LSB first
            end
        end
        wait_idle("load");
    endtask

    task automatic expect_reply(input string name, input logic [31:0] expected);
        exp_q.push_back(expected);
        name_q.push_back(name);
        n_expected++;
        wait (n_replies == n_expected);
        wait_idle(name);
    endtask

    task automatic report_test(input int err_before);
        if (errors == err_before) begin
            $display("Test %s passed", cur_test);
        end else begin
            $display("Test %s failed with %0d errors", cur_test, errors - err_before);
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin : monitor
        logic [7:0]  data;
        logic [31:0] word;
        int          k;
        forever begin
            for (k = 0; k < 4; k++) begin
                receive_byte(data);
                word[8*k +: 8] = data;
            end
            got_q.push_back(word);
            n_words++;
        end
    end

    initial begin : compare
        logic [31:0] got;
        forever begin
            wait (n_words > n_replies);
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("Reply %h arrived in test %s when none was expected", got, cur_test);
            end else begin
                check(name_q.pop_front(), exp_q.pop_front(), got);
            end
            n_replies++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Watchdog expired in test %s, the DUT stopped answering", cur_test);
        errors++;
        end_run();
    end

    initial begin : main
        int i;
        int pc;
        int err0;
        int jump_at;
        int target;
        arst_n  = 1'b0;
        uart_rx = 1'b1;                 // Idle line
        void'($urandom(SEED));
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        repeat (4) @(posedge clock);

        cur_test = "load_dump";
        err0 = errors;
        build_straight(LEN_A);
        load_program(LEN_A);
        for (i = 0; i < LEN_A; i++) begin
            send_byte(CMD_DUMP);
            send_byte({2'($urandom()), 6'(i)});    // Top bits fall outside the address
            expect_reply($sformatf("dump[%0d]", i), image[i]);
        end
        report_test(err0);

        cur_test = "run_halt";
        err0 = errors;
        send_byte(CMD_RUN);
        expect_reply("run", 32'(ref_run(image, 0, RUN_LIMIT)));
        report_test(err0);

        // Jump lands in words left over from the first program
        cur_test = "jump";
        err0 = errors;
        build_straight(LEN_J);
        jump_at = 1 + $urandom_range(2);
        target  = LEN_J + $urandom_range(LEN_A - LEN_J - 2);
        image[jump_at] = jump_word(target);
        load_program(LEN_J);
        send_byte(CMD_RUN);
        expect_reply("jump run", 32'(ref_run(image, 0, RUN_LIMIT)));
        report_test(err0);

        cur_test = "step";
        err0 = errors;
        build_straight(LEN_S);
        load_program(LEN_S);
        pc = 0;
        for (i = 0; i < N_STEPS; i++) begin
            send_byte(CMD_STEP);
            pc = ref_run(image, pc, 1);
            expect_reply($sformatf("step[%0d]", i), 32'(pc));
        end
        report_test(err0);

        cur_test = "reload";
        err0 = errors;
        build_straight(LEN_R);
        load_program(LEN_R);
        check("reload halt", 32'd0, {31'd0, hlt});
        send_byte(CMD_RUN);
        expect_reply("reload run", 32'(ref_run(image, 0, RUN_LIMIT)));
        report_test(err0);

        end_run();
    end

endmodule

`default_nettype wire

//--- project.f
rtl/dbg_pkg.sv
rtl/baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/debug_unit.sv
rtl/dbg_top.sv
tests/tb_clock_gen.sv
tests/dbg_asserts.sv
tests/tb_dbg_top.sv

//--- Bender.yml
package:
  name: uart_debug_unit

sources:
  - rtl/dbg_pkg.sv
  - rtl/baud_gen.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/instr_mem.sv
  - rtl/fetch_unit.sv
  - rtl/debug_unit.sv
  - rtl/dbg_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/dbg_asserts.sv
      - tests/tb_dbg_top.sv
